/* flist.f */
hdl/video_pkg.sv
hdl/video_ifs.sv
hdl/raster_timer.sv
hdl/vmem_arbiter.sv
hdl/video_fetch.sv
hdl/pixel_render.sv
hdl/video_top.sv
testbench/video_asserts.sv
testbench/video_tb.sv

/* hdl/pixel_render.sv */
`timescale 1ns/1ps

module pixel_render (
	input  logic             clk,
	input  logic             rst,
	input  logic             cend,
	pix_word_if.dst          dst,
	output video_pkg::rgb_t  pixel,
	output logic             pixel_valid
);

	localparam int PW = $clog2(video_pkg::WORD_PIXELS);

	video_pkg::vram_data_t [3:0] grp;
	video_pkg::vmode_t           mode;
	logic                        flash;
	logic                        win;    // inside the visible window
	logic [PW-1:0]               pixnum; // 0 = leftmost

	logic [7:0] attr;
	logic [7:0] pbyte;
	logic       ink_sel;
	logic [3:0] color; // bright, g, r, b

	// group payload taken as is on load
	always_ff @(posedge clk)
	begin
		if (dst.load)
		begin
			grp   <= dst.group;
			mode  <= dst.mode;
			flash <= dst.flash_en;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			win    <= 1'b0;
			pixnum <= '0;
		end
		else if (dst.load)
		begin
			win    <= dst.pix_en;
			pixnum <= '0;
		end
		else if (cend)
			pixnum <= pixnum + 1'b1;
	end

	always_comb
	begin
		attr    = pixnum[3] ? grp[1][7:0] : grp[1][15:8]; // one attr per 8 pixels
		pbyte   = pixnum[3] ? grp[pixnum[2:1]][7:0] : grp[pixnum[2:1]][15:8];
		ink_sel = grp[0][~pixnum] ^ (flash & attr[7]); // msb first
		if (mode[1])
			color = pixnum[0] ? {pbyte[7], pbyte[5:3]} : {pbyte[6], pbyte[2:0]};
		else if (ink_sel)
			color = {attr[6], attr[2:0]}; // ink
		else
			color = {attr[6], attr[5:3]}; // paper
	end

	// each bit to 00, 10, or 11 when bright
	assign pixel[5:4] = win & color[1] ? {1'b1, color[3]} : 2'b00; // red
	assign pixel[3:2] = win & color[2] ? {1'b1, color[3]} : 2'b00; // green
	assign pixel[1:0] = win & color[0] ? {1'b1, color[3]} : 2'b00; // blue

	assign pixel_valid = win;

endmodule

/* hdl/raster_timer.sv */
`timescale 1ns/1ps

module raster_timer #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320,
	parameter int V_START = 64
)(
	input  logic clk,
	input  logic rst,
	output logic cend,        // pixel enable, every second clock
	output logic line_start,
	output logic vpix,        // active line window
	output logic frame_start
);

	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	logic [HW-1:0] hcnt; // pixel cycle within line
	logic [VW-1:0] vcnt; // line within frame

	// clock divider
	always_ff @(posedge clk)
	begin
		if (rst)
			cend <= 1'b0;
		else
			cend <= ~cend;
	end

	// horizontal count, only moves on pixel cycles
	always_ff @(posedge clk)
	begin
		if (rst)
			hcnt <= '0;
		else if (cend)
		begin
			if (hcnt == HW'(H_TOTAL - 1))
				hcnt <= '0; // wrap to next line
			else
				hcnt <= hcnt + 1'b1;
		end
	end

	// vertical count, steps at the end of each line
	always_ff @(posedge clk)
	begin
		if (rst)
			vcnt <= '0;
		else if (cend && hcnt == HW'(H_TOTAL - 1))
		begin
			if (vcnt == VW'(V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end
	end

	assign line_start  = cend & (hcnt == '0);  // first pixel cycle of a line
	assign frame_start = line_start & (vcnt == '0);

	// vcnt already holds the new line at line_start
	// compared as integers so the window end may exceed vcnt's range
	assign vpix = (int'(vcnt) >= V_START) && (int'(vcnt) < V_START + video_pkg::V_ACTIVE);

endmodule

/* hdl/video_fetch.sv */
`timescale 1ns/1ps

module video_fetch #(
	parameter int FLASH_BITS = 5
)(
	input  logic               clk,
	input  logic               rst,
	input  logic               cend,
	input  logic               line_start,
	input  logic               vpix,
	input  logic               frame_start,
	input  video_pkg::vmode_t  vmode,
	input  logic               screen,   // page bit of every address
	vmem_req_if.req            req,
	pix_word_if.src            src
);

	// groups inside the window, one more is fetched to close it
	localparam int GROUPS = video_pkg::H_ACTIVE / video_pkg::WORD_PIXELS;
	// last pixel cycle of a group, first load lands just before PIX_START
	localparam logic [3:0] WLAST = 4'(video_pkg::PIX_START - video_pkg::START_FETCH - 1);

	video_pkg::line_t      vcnt;  // active line
	logic [3:0]            hcnt;  // word column 0..15
	logic [1:0]            dcnt;  // displacement, pix/attr or plane
	logic [1:0]            ddcnt; // dcnt kept for the returning word
	logic [5:0]            scnt;  // start-fetch countdown
	logic [3:0]            wcnt;  // pixel cycle within group
	logic [4:0]            fcnt;  // groups done this line
	logic [FLASH_BITS-1:0] flashctr;

	logic                  go_start;
	logic                  go_end;
	logic                  load;
	logic [11:0]           inter; // zx line interleave plus column
	logic [13:0]           off;

	video_pkg::vram_data_t fbuf [0:3];

	// frame counter, top bit is the flash phase
	always_ff @(posedge clk)
	begin
		if (rst)
			flashctr <= '0;
		else if (frame_start)
			flashctr <= flashctr + 1'b1;
	end

	// line counter, preset so the first active line is 0
	always_ff @(posedge clk)
	begin
		if (rst || frame_start)
			vcnt <= 8'hFF;
		else if (line_start && vpix)
			vcnt <= vcnt + 8'd1;
	end

	// countdown from line start to go
	always_ff @(posedge clk)
	begin
		if (rst)
			scnt <= '0;
		else if (cend)
		begin
			if (line_start && vpix)
				scnt <= 6'(video_pkg::START_FETCH - 1);
			else if (scnt != 6'd0)
				scnt <= scnt - 6'd1;
		end
	end
	assign go_start = cend & (scnt == 6'd1); // go is up from the next pixel cycle

	// group phase, same count as the arbiter slot phase
	always_ff @(posedge clk)
	begin
		if (rst || go_start)
			wcnt <= '0;
		else if (cend)
			wcnt <= wcnt + 4'd1;
	end

	assign load   = req.go & cend & (wcnt == WLAST);
	assign go_end = load & (fcnt == 5'(GROUPS)); // after GROUPS+1 groups

	always_ff @(posedge clk)
	begin
		if (rst || go_start)
			fcnt <= '0;
		else if (load && fcnt != 5'(GROUPS))
			fcnt <= fcnt + 5'd1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			req.go <= 1'b0;
		else if (go_start)
			req.go <= 1'b1;
		else if (go_end)
			req.go <= 1'b0;
	end

	assign req.bw = vmode[1]; // four words only for p16c

	// column and displacement advance on each taken address
	always_ff @(posedge clk)
	begin
		if (rst || line_start)
		begin
			hcnt  <= '0;
			dcnt  <= '0;
			ddcnt <= '0;
		end
		else if (req.next)
		begin
			ddcnt <= dcnt;
			dcnt  <= dcnt + 2'd1;
			if (vmode[1] ? (dcnt == 2'd3) : dcnt[0])
				hcnt <= hcnt + 4'd1; // last word of the group
		end
	end

	// addresses within the page
	always_comb
	begin
		inter = {vcnt[7:6], vcnt[2:0], vcnt[5:3], hcnt};
		if (vmode[1])
			off = {dcnt[0], dcnt[1], inter}; // one plane per quarter
		else if (!dcnt[0])
			off = {2'b10, inter};            // bitmap
		else if (vmode == video_pkg::MODE_MULTICOLOR)
			off = {2'b11, inter};            // attr per pixel line
		else
			off = {5'b10110, vcnt[7:3], hcnt}; // byte 0x1800 + row*32 of the screen
	end
	assign req.addr = {screen, off};

	// store returned word by saved displacement
	always_ff @(posedge clk)
	begin
		if (req.strobe)
			fbuf[vmode[1] ? ddcnt : {1'b0, ddcnt[0]}] <= req.data;
	end

	assign src.load     = load;
	assign src.group    = {fbuf[3], fbuf[2], fbuf[1], fbuf[0]};
	assign src.mode     = vmode;
	assign src.flash_en = flashctr[FLASH_BITS-1];
	assign src.pix_en   = (fcnt < 5'(GROUPS)); // the extra group shuts the window

endmodule

/* hdl/video_ifs.sv */
`timescale 1ns/1ps

// fetch side asks for words, arbiter answers
interface vmem_req_if;

	logic                   go;     // fetch window of a line
	video_pkg::fetch_bw_t   bw;     // words per group class
	video_pkg::vram_addr_t  addr;   // word to read next
	logic                   next;   // addr taken, advance
	logic                   strobe; // data valid, one clock after next
	video_pkg::vram_data_t  data;

	modport mem
	(
		input  go, bw, addr,
		output next, strobe, data
	);

	modport req
	(
		output go, bw, addr,
		input  next, strobe, data
	);

endinterface

// completed word groups from fetch to the renderer
interface pix_word_if;

	logic                            load;     // one clock at group boundary
	video_pkg::vram_data_t [3:0]     group;    // word 0 in 15..0
	video_pkg::vmode_t               mode;
	logic                            flash_en; // current flash phase
	logic                            pix_en;   // group lies inside the window

	modport src
	(
		output load, group, mode, flash_en, pix_en
	);

	modport dst
	(
		input load, group, mode, flash_en, pix_en
	);

endinterface

/* hdl/video_pkg.sv */
package video_pkg;

	// video memory word address: bit 14 = screen page, 13..0 = offset in page
	typedef logic [14:0] vram_addr_t;
	typedef logic [15:0] vram_data_t; // one memory word, left byte in 15..8

	typedef logic [1:0] vmode_t; // display mode code
	typedef logic [5:0] rgb_t;   // rr gg bb
	typedef logic [7:0] line_t;  // active line 0..191

	// 0 = two words per 16 pixels, 1 = four words
	typedef logic fetch_bw_t;

	// mode codes, p16c is any code with bit 1 set
	localparam vmode_t MODE_ZX         = 2'd0;
	localparam vmode_t MODE_MULTICOLOR = 2'd1;
	localparam vmode_t MODE_P16C       = 2'd2;

	// raster constants in pixel cycles
	localparam int START_FETCH = 36; // line start to first fetch
	localparam int PIX_START   = 52; // line start to first visible pixel
	localparam int H_ACTIVE    = 256;
	localparam int V_ACTIVE    = 192;
	localparam int WORD_PIXELS = 16; // pixels per fetch group

endpackage

/* hdl/video_top.sv */
`timescale 1ns/1ps

module video_top #(
	parameter int H_TOTAL    = 448,
	parameter int V_TOTAL    = 320,
	parameter int V_START    = 64,
	parameter int FLASH_BITS = 5
)(
	input  logic                  clk,
	input  logic                  rst,
	input  video_pkg::vmode_t     vmode,  // static per frame
	input  logic                  screen,
	input  logic                  cpu_wr,
	input  video_pkg::vram_addr_t cpu_addr,
	input  video_pkg::vram_data_t cpu_data,
	output video_pkg::rgb_t       pixel,
	output logic                  pixel_valid,
	output logic                  frame_start
);

	logic cend;
	logic line_start;
	logic vpix;

	vmem_req_if mem_bus ();
	pix_word_if pix_bus ();

	raster_timer #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL),
		.V_START (V_START)
	) u_timer (
		.clk         (clk),
		.rst         (rst),
		.cend        (cend),
		.line_start  (line_start),
		.vpix        (vpix),
		.frame_start (frame_start)
	);

	vmem_arbiter u_arb (
		.clk      (clk),
		.rst      (rst),
		.cpu_wr   (cpu_wr),
		.cpu_addr (cpu_addr),
		.cpu_data (cpu_data),
		.cend     (cend),
		.mem      (mem_bus.mem)
	);

	video_fetch #(
		.FLASH_BITS (FLASH_BITS)
	) u_fetch (
		.clk         (clk),
		.rst         (rst),
		.cend        (cend),
		.line_start  (line_start),
		.vpix        (vpix),
		.frame_start (frame_start),
		.vmode       (vmode),
		.screen      (screen),
		.req         (mem_bus.req),
		.src         (pix_bus.src)
	);

	pixel_render u_render (
		.clk         (clk),
		.rst         (rst),
		.cend        (cend),
		.dst         (pix_bus.dst),
		.pixel       (pixel),
		.pixel_valid (pixel_valid)
	);

endmodule

/* hdl/vmem_arbiter.sv */
`timescale 1ns/1ps

module vmem_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cpu_wr,   // one clock write strobe
	input  video_pkg::vram_addr_t cpu_addr,
	input  video_pkg::vram_data_t cpu_data,
	input  logic                  cend,
	vmem_req_if.mem               mem
);

	// 32K words, both screen pages
	video_pkg::vram_data_t ram [0:(1 << 15) - 1];

	logic [3:0]            phase; // pixel cycle within the 16 pixel group
	logic                  grant;
	video_pkg::vram_data_t rd_q;

	logic                  pend;  // cpu write waiting
	video_pkg::vram_addr_t wa;
	video_pkg::vram_data_t wd;

	// slot phase runs only while go is up, so slot 0 is the first fetch cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= '0;
		else if (!mem.go)
			phase <= '0;
		else if (cend)
			phase <= phase + 1'b1;
	end

	// a slot every fourth pixel cycle
	// bw 0 keeps only slots 0 and 1 of each group
	assign grant = mem.go & cend & (phase[1:0] == 2'b00) & (mem.bw | ~phase[3]);
	assign mem.next = grant;

	// single port ram, video read wins, cpu write takes any other clock
	always_ff @(posedge clk)
	begin
		if (grant)
			rd_q <= ram[mem.addr];
		else if (pend)
			ram[wa] <= wd;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			mem.strobe <= 1'b0;
		else
			mem.strobe <= grant; // registered read lands here
	end

	assign mem.data = rd_q;

	// latch of the one pending cpu write
	always_ff @(posedge clk)
	begin
		if (cpu_wr)
		begin
			wa <= cpu_addr;
			wd <= cpu_data;
		end
	end

	// grants only come on cend clocks, so a write retires within two clocks
	always_ff @(posedge clk)
	begin
		if (rst)
			pend <= 1'b0;
		else if (cpu_wr)
			pend <= 1'b1; // new write, keeps pend up even when the old one retires
		else if (!grant)
			pend <= 1'b0;
	end

endmodule

/* testbench/video_asserts.sv */
`timescale 1ns/1ps

module video_asserts (
	input logic            clk,
	input logic            rst,
	input logic            go,
	input logic            next,
	input logic            strobe,
	input logic            cpu_wr,
	input logic            pend,        // arbiter holds a cpu write
	input video_pkg::rgb_t pixel,
	input logic            pixel_valid
);

	int err_cnt = 0; // failed assertions so far

	// registered read answers every grant
	strobe_after_next: assert property (@(posedge clk) disable iff (rst) next |=> strobe)
	else
	begin
		$error("strobe missing one clock after next");
		err_cnt++;
	end

	strobe_needs_next: assert property (@(posedge clk) disable iff (rst)
		strobe |-> $past(next))
	else
	begin
		$error("strobe without a grant one clock before");
		err_cnt++;
	end

	// slots only inside the fetch window
	next_in_window: assert property (@(posedge clk) disable iff (rst) next |-> go)
	else
	begin
		$error("next outside of go");
		err_cnt++;
	end

	blank_outside: assert property (@(posedge clk) disable iff (rst)
		!pixel_valid |-> pixel == '0)
	else
	begin
		$error("pixel not black outside the window");
		err_cnt++;
	end

	// only one write held at a time
	wr_not_pending: assert property (@(posedge clk) disable iff (rst) cpu_wr |-> !pend)
	else
	begin
		$error("cpu write while one is pending");
		err_cnt++;
	end

endmodule

bind video_top video_asserts u_asserts (
	.clk         (clk),
	.rst         (rst),
	.go          (mem_bus.go),
	.next        (mem_bus.next),
	.strobe      (mem_bus.strobe),
	.cpu_wr      (cpu_wr),
	.pend        (u_arb.pend),
	.pixel       (pixel),
	.pixel_valid (pixel_valid)
);

/* testbench/video_tb.sv */
`timescale 1ns/1ps

module video_tb;

	localparam int H_TOTAL    = 448;
	localparam int V_TOTAL    = 200;
	localparam int V_START    = 4;  // 192 active lines fit the short frame
	localparam int FLASH_BITS = 1;  // flash phase flips every frame
	localparam int LIMIT      = 6 * H_TOTAL * V_TOTAL * 2 + 2000; // clocks

	logic                  clk;
	logic                  rst;
	video_pkg::vmode_t     vmode;
	logic                  screen;
	logic                  cpu_wr;
	video_pkg::vram_addr_t cpu_addr;
	video_pkg::vram_data_t cpu_data;
	video_pkg::rgb_t       pixel;
	logic                  pixel_valid;
	logic                  frame_start;

	video_pkg::vram_data_t shadow [0:32767]; // mirror of every cpu write
	video_pkg::vram_data_t view   [0:32767]; // memory as seen by this frame

	int seed       = 11;
	int frames     = 0; // frame_start pulses so far
	int frame_clks = 0; // clocks since the last frame_start
	int y_cnt      = 0; // valid lines in this frame
	int run_clks   = 0; // clocks of the current valid run
	int lines_done = 0; // lines compared
	int cycles     = 0;

	video_top #(
		.H_TOTAL    (H_TOTAL),
		.V_TOTAL    (V_TOTAL),
		.V_START    (V_START),
		.FLASH_BITS (FLASH_BITS)
	) dut (
		.clk         (clk),
		.rst         (rst),
		.vmode       (vmode),
		.screen      (screen),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_data    (cpu_data),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.frame_start (frame_start)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	// one cpu write and 7 idle clocks before the next
	task automatic write_word(input int a, input video_pkg::vram_data_t d);
		@(negedge clk);
		cpu_wr    = 1'b1;
		cpu_addr  = 15'(a);
		cpu_data  = d;
		shadow[a] = d;
		@(negedge clk);
		cpu_wr = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	// colour bit to 2-bit level
	function automatic logic [1:0] level(input logic on, input logic bright);
		return on ? {1'b1, bright} : 2'b00;
	endfunction

	// page offset of each p16c plane in fetch order
	function automatic int plane_base(input int k);
		case (k)
			1: return 'h2000;
			2: return 'h1000;
			3: return 'h3000;
			default: return 0;
		endcase
	endfunction

	function automatic video_pkg::rgb_t expect_pixel(input int x, input int y);
		int          col;
		int          bx;    // pixel within the 16 pixel word
		int          base;
		int          inter; // third, char line, char row, column
		logic [15:0] bm;
		logic [15:0] aw;
		logic [7:0]  ab;
		logic [7:0]  pb;
		logic        ink;
		logic [3:0]  c;     // bright, g, r, b
		col   = x / 16;
		bx    = x % 16;
		base  = screen ? 'h4000 : 0;
		inter = (y / 64) * 1024 + (y % 8) * 128 + ((y / 8) % 8) * 16 + col;
		if (vmode[1])
		begin
			pb = view[base + plane_base((bx / 2) % 4) + inter][((bx < 8) ? 15 : 7) -: 8];
			c  = (bx % 2 == 0) ? {pb[6], pb[2:0]} : {pb[7], pb[5:3]}; // nibble pairs
		end
		else
		begin
			bm = view[base + 'h2000 + inter];
			if (vmode == video_pkg::MODE_MULTICOLOR)
				aw = view[base + 'h3000 + inter];                  // per pixel line
			else
				aw = view[base + 'h2C00 + (y / 8) * 16 + col];     // per 8 line row
			ab  = (bx < 8) ? aw[15:8] : aw[7:0];
			ink = bm[15 - bx] ^ (frames[0] & ab[7]);             // flash swaps
			c   = ink ? {ab[6], ab[2:0]} : {ab[6], ab[5:3]};
		end
		return {level(c[1], c[3]), level(c[2], c[3]), level(c[0], c[3])};
	endfunction

	// reference walk of the output stream from frame 2 on
	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (dut.u_asserts.err_cnt == 0)
			else abort_run("a bound protocol assertion failed");
			if (frames == 0)
			begin
				assert (!pixel_valid && pixel == '0)
				else abort_run($sformatf("[FAIL] %0t output active before frame start", $time));
			end
			if (frame_start)
			begin
				if (frames >= 1)
				begin
					assert (frame_clks == 2 * H_TOTAL * V_TOTAL)
					else abort_run($sformatf("[FAIL] %0t frame lasted %0d clocks",
						$time, frame_clks));
				end
				if (frames >= 2)
				begin
					assert (y_cnt == video_pkg::V_ACTIVE)
					else abort_run($sformatf("[FAIL] %0t frame had %0d lines", $time, y_cnt));
					lines_done += y_cnt;
				end
				frames++;
				frame_clks = 0;
				y_cnt      = 0;
				view       = shadow; // writes so far show in this frame
			end
			frame_clks++;
			if (pixel_valid)
			begin
				if (frames >= 2)
				begin
					assert (y_cnt < video_pkg::V_ACTIVE && pixel == expect_pixel(run_clks / 2, y_cnt))
					else abort_run($sformatf("[FAIL] %0t pixel %0d line %0d is %h, expected %h",
						$time, run_clks / 2, y_cnt, pixel, expect_pixel(run_clks / 2, y_cnt)));
				end
				run_clks++;
			end
			else if (run_clks != 0)
			begin
				if (frames >= 2)
				begin
					assert (run_clks == 2 * video_pkg::H_ACTIVE)
					else abort_run($sformatf("[FAIL] %0t line %0d valid for %0d clocks",
						$time, y_cnt, run_clks));
				end
				run_clks = 0; // end of a line
				y_cnt++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > LIMIT)
			abort_run("timeout, the run never reached its last frame");
	end

	initial
	begin
		rst      = 1'b1;
		vmode    = video_pkg::MODE_ZX;
		screen   = 1'b0;
		cpu_wr   = 1'b0;
		cpu_addr = '0;
		cpu_data = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// frame 1 fills page 0 bitmap/attr/multicolor and the page 1 planes
		wait (frames == 1);
		for (int a = 'h2000; a < 'h3C00; a++)
			write_word(a, 16'($random(seed)));
		for (int k = 0; k < 4; k++)
			for (int i = 0; i < 'hC00; i++)
				write_word('h4000 + plane_base(k) + i, 16'($random(seed)));

		// frame 2 zx with lines 0..7 rewritten once shown
		// the new words are due in frame 3
		wait (frames == 2);
		wait (y_cnt >= 16);
		for (int y = 0; y < 8; y++)
			for (int c = 0; c < 16; c++)
				write_word('h2000 + y * 128 + c, 16'($random(seed)));
		for (int c = 0; c < 16; c++)
			write_word('h2C00 + c, 16'($random(seed))); // attr row 0

		wait (frames == 4); // mode switch during the blank lines at frame top
		@(negedge clk);
		vmode = video_pkg::MODE_MULTICOLOR;
		wait (frames == 5);
		@(negedge clk);
		vmode  = video_pkg::MODE_P16C;
		screen = 1'b1;

		wait (frames == 6);
		@(negedge clk);
		if (lines_done == 4 * video_pkg::V_ACTIVE)
		begin
			$display("sim passed");
			$finish;
		end
		else
			abort_run($sformatf("[FAIL] %0t compared %0d lines, expected %0d",
				$time, lines_done, 4 * video_pkg::V_ACTIVE));
	end

endmodule
